/* hw/dcache_pkg.sv */
package dcache_pkg;

    // ========================================
    // Cache geometry
    // ========================================
    localparam int XLEN           = 32;                // Core word width
    localparam int LINE_W         = 128;               // Line width, four words
    localparam int N_WAYS         = 4;
    localparam int N_SETS         = 16;
    localparam int BYTES_PER_WORD = XLEN / 8;

    localparam int WAY_BITS  = $clog2(N_WAYS);         // 2
    localparam int SET_BITS  = $clog2(N_SETS);         // 4
    localparam int WORD_BITS = $clog2(LINE_W / XLEN);  // 2
    localparam int BYTE_BITS = $clog2(BYTES_PER_WORD); // 2
    localparam int TAG_BITS  = XLEN - SET_BITS - WORD_BITS - BYTE_BITS;

    // Bit positions of the address fields
    localparam int OFFS_LSB = BYTE_BITS;
    localparam int SET_LSB  = OFFS_LSB + WORD_BITS;
    localparam int TAG_LSB  = SET_LSB + SET_BITS;

    // ========================================
    // Data and address types
    // ========================================
    typedef logic [XLEN-1:0]           word_t;
    typedef logic [LINE_W-1:0]         line_t;  // Word k sits at bits [k*32 +: 32]
    typedef logic [BYTES_PER_WORD-1:0] be_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [SET_BITS-1:0]       set_t;
    typedef logic [WORD_BITS-1:0]      offs_t;
    typedef logic [WAY_BITS-1:0]       way_t;
    typedef logic [XLEN-1:0]           addr_t;  // Byte address

    // Controller FSM
    typedef enum logic [2:0] {
        ST_IDLE,       // Waiting for a core strobe
        ST_LOOKUP,     // Tags valid, hit or miss decided here
        ST_WB,         // Dirty victim going out
        ST_WB_DONE,
        ST_FILL,       // Line refill pending
        ST_FILL_DONE   // Install line and answer the core
    } dcache_state_e;

    // Memory request kind
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

/* hw/dcache_tag_array.sv */
module dcache_tag_array
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  dcache_pkg::set_t    set_i,          // Read and write set
    input  dcache_pkg::tag_t    tag_i,          // Tag of the registered request
    input  logic                fill_we_i,      // Write tag and set valid
    input  dcache_pkg::way_t    fill_way_i,
    input  logic                dirty_we_i,
    input  dcache_pkg::way_t    dirty_way_i,
    input  logic                dirty_val_i,
    input  dcache_pkg::way_t    victim_way_i,
    output logic                hit_o,
    output dcache_pkg::way_t    hit_way_o,
    output logic                victim_dirty_o,
    output dcache_pkg::tag_t    victim_tag_o
);

    dcache_pkg::tag_t               tags_q [dcache_pkg::N_WAYS][dcache_pkg::N_SETS];
    logic [dcache_pkg::N_SETS-1:0]  valid_q [dcache_pkg::N_WAYS];
    logic [dcache_pkg::N_SETS-1:0]  dirty_q [dcache_pkg::N_WAYS];

    dcache_pkg::tag_t               rd_tag_q [dcache_pkg::N_WAYS];  // Read port registers
    logic [dcache_pkg::N_WAYS-1:0]  rd_valid_q;
    logic [dcache_pkg::N_WAYS-1:0]  rd_dirty_q;
    logic [dcache_pkg::N_WAYS-1:0]  way_hit;

    // Tag storage
    always_ff @(posedge clk_i)
    begin
        if (fill_we_i)
        begin
            tags_q[fill_way_i][set_i] <= tag_i;  // New owner of the way
        end
    end

    // Valid and dirty flags
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int w = 0; w < dcache_pkg::N_WAYS; w++)
            begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end
        else
        begin
            if (fill_we_i)
                valid_q[fill_way_i][set_i] <= 1'b1;
            if (dirty_we_i)
                dirty_q[dirty_way_i][set_i] <= dirty_val_i;  // Clean fill clears, write sets
        end
    end

    // Synchronous read of all ways of the set
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < dcache_pkg::N_WAYS; w++)
        begin
            rd_tag_q[w]   <= tags_q[w][set_i];
            rd_valid_q[w] <= valid_q[w][set_i];
            rd_dirty_q[w] <= dirty_q[w][set_i];
        end
    end

    // Compare and encode the hit way
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < dcache_pkg::N_WAYS; w++)
        begin
            way_hit[w] = rd_valid_q[w] && (rd_tag_q[w] == tag_i);
            if (way_hit[w])
                hit_way_o = dcache_pkg::way_t'(w);  // At most one way matches
        end
    end

    assign hit_o          = |way_hit;
    assign victim_dirty_o = rd_dirty_q[victim_way_i];
    assign victim_tag_o   = rd_tag_q[victim_way_i];   // Rebuilds the write-back address

endmodule

/* hw/dcache_data_array.sv */
module dcache_data_array
(
    input  logic                clk_i,
    input  dcache_pkg::set_t    set_i,
    input  dcache_pkg::offs_t   offs_i,       // Word within the line
    input  logic                we_i,         // Line write strobe
    input  dcache_pkg::way_t    way_i,        // Way for read mux and write
    input  logic                fill_i,       // Base is the refill line
    input  dcache_pkg::line_t   fill_line_i,
    input  logic                wr_i,         // Merge core data into the line
    input  dcache_pkg::be_t     be_i,
    input  dcache_pkg::word_t   wdata_i,
    output dcache_pkg::line_t   line_o,
    output dcache_pkg::word_t   word_o
);

    dcache_pkg::line_t lines_q [dcache_pkg::N_WAYS][dcache_pkg::N_SETS];
    dcache_pkg::line_t rd_line_q [dcache_pkg::N_WAYS];
    dcache_pkg::line_t base_line;
    dcache_pkg::line_t new_line;
    dcache_pkg::word_t base_word;
    dcache_pkg::word_t merged_word;

    // ========================================
    // Storage and synchronous read
    // ========================================
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < dcache_pkg::N_WAYS; w++)
        begin
            rd_line_q[w] <= lines_q[w][set_i];  // All ways of the set
        end
        if (we_i)
        begin
            lines_q[way_i][set_i] <= new_line;
        end
    end

    assign line_o = rd_line_q[way_i];

    // Hit line or refill line as the source
    assign base_line = fill_i ? fill_line_i : line_o;
    assign base_word = base_line[offs_i * dcache_pkg::XLEN +: dcache_pkg::XLEN];
    assign word_o    = base_word;  // Read data back to the core

    // ========================================
    // Byte-enable merge
    // ========================================
    always_comb
    begin
        merged_word = base_word;
        for (int b = 0; b < dcache_pkg::BYTES_PER_WORD; b++)
        begin
            if (be_i[b])
                merged_word[b*8 +: 8] = wdata_i[b*8 +: 8];  // Take core byte
        end
    end

    always_comb
    begin
        new_line = base_line;  // Plain refill when not writing
        if (wr_i)
        begin
            new_line[offs_i * dcache_pkg::XLEN +: dcache_pkg::XLEN] = merged_word;
        end
    end

endmodule

/* hw/dcache_fifo_repl.sv */
module dcache_fifo_repl
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  dcache_pkg::set_t    set_i,
    input  logic                advance_i,   // One fill completed in set_i
    output dcache_pkg::way_t    victim_o
);

    dcache_pkg::way_t cnt_q [dcache_pkg::N_SETS];  // Next way to replace, per set

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < dcache_pkg::N_SETS; s++)
            begin
                cnt_q[s] <= '0;
            end
        end
        else if (advance_i)
        begin
            cnt_q[set_i] <= cnt_q[set_i] + 1'b1;  // Wraps after the last way
        end
    end

    // Registered read like the arrays
    always_ff @(posedge clk_i)
    begin
        victim_o <= cnt_q[set_i];
    end

endmodule

/* hw/dcache_ctrl.sv */
module dcache_ctrl
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    p_strobe_i,
    input  logic                    rw_i,             // Registered request, 1 is write
    input  logic                    hit_i,
    input  dcache_pkg::way_t        hit_way_i,
    input  dcache_pkg::way_t        victim_i,
    input  logic                    victim_dirty_i,
    input  dcache_pkg::tag_t        victim_tag_i,
    input  dcache_pkg::set_t        set_i,
    input  dcache_pkg::line_t       victim_line_i,
    input  dcache_pkg::addr_t       fill_addr_i,
    input  logic                    m_ready_i,
    output logic                    p_ready_o,
    output logic                    fill_o,
    output dcache_pkg::way_t        way_sel_o,
    output logic                    data_we_o,
    output logic                    fill_we_o,
    output logic                    dirty_we_o,
    output logic                    dirty_val_o,
    output logic                    advance_o,
    output logic                    m_strobe_o,
    output dcache_pkg::mem_op_e     m_rw_o,
    output dcache_pkg::addr_t       m_addr_o,
    output dcache_pkg::line_t       m_data_o
);

    dcache_pkg::dcache_state_e state_q, state_d;

    logic lookup_hit;
    logic wb_enter;
    logic fill_enter;

    // ========================================
    // State machine
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= dcache_pkg::ST_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;  // Hold while memory stalls
        case (state_q)
            dcache_pkg::ST_IDLE:
                if (p_strobe_i)
                    state_d = dcache_pkg::ST_LOOKUP;
            dcache_pkg::ST_LOOKUP:
                if (hit_i)
                    state_d = dcache_pkg::ST_IDLE;
                else if (victim_dirty_i)
                    state_d = dcache_pkg::ST_WB;    // Evict first
                else
                    state_d = dcache_pkg::ST_FILL;
            dcache_pkg::ST_WB:
                if (m_ready_i)
                    state_d = dcache_pkg::ST_WB_DONE;
            dcache_pkg::ST_WB_DONE:
                state_d = dcache_pkg::ST_FILL;
            dcache_pkg::ST_FILL:
                if (m_ready_i)
                    state_d = dcache_pkg::ST_FILL_DONE;
            dcache_pkg::ST_FILL_DONE:
                state_d = dcache_pkg::ST_IDLE;
            default:
                state_d = dcache_pkg::ST_IDLE;
        endcase
    end

    // Array and core controls
    assign lookup_hit  = (state_q == dcache_pkg::ST_LOOKUP) && hit_i;
    assign fill_o      = (state_q == dcache_pkg::ST_FILL_DONE);
    assign p_ready_o   = lookup_hit || fill_o;
    assign way_sel_o   = lookup_hit ? hit_way_i : victim_i;  // Victim during a miss
    assign data_we_o   = (lookup_hit && rw_i) || fill_o;      // Write hit or install
    assign fill_we_o   = fill_o;
    assign dirty_we_o  = data_we_o;
    assign dirty_val_o = rw_i;                                 // Write-allocate leaves it dirty
    assign advance_o   = fill_o;

    // ========================================
    // Memory request
    // ========================================
    assign wb_enter   = (state_d == dcache_pkg::ST_WB) && (state_q != dcache_pkg::ST_WB);
    assign fill_enter = (state_d == dcache_pkg::ST_FILL) && (state_q != dcache_pkg::ST_FILL);

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_rw_o     <= dcache_pkg::MEM_READ;
        end
        else
        begin
            m_strobe_o <= wb_enter || fill_enter;  // Single pulse per request
            if (wb_enter)
                m_rw_o <= dcache_pkg::MEM_WRITE;
            else if (fill_enter)
                m_rw_o <= dcache_pkg::MEM_READ;
        end
    end

    // Address and line held until the next request
    always_ff @(posedge clk_i)
    begin
        if (wb_enter)
        begin
            m_addr_o <= {victim_tag_i, set_i, {dcache_pkg::SET_LSB{1'b0}}};
            m_data_o <= victim_line_i;
        end
        else if (fill_enter)
        begin
            m_addr_o <= {fill_addr_i[dcache_pkg::XLEN-1:dcache_pkg::SET_LSB],
                         {dcache_pkg::SET_LSB{1'b0}}};  // Line aligned
        end
    end

endmodule

/* hw/dcache_top.sv */
module dcache_top
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    // Core port
    input  logic                    p_strobe_i,
    input  logic                    p_rw_i,
    input  dcache_pkg::be_t         p_be_i,
    input  dcache_pkg::addr_t       p_addr_i,
    input  dcache_pkg::word_t       p_data_i,
    output dcache_pkg::word_t       p_data_o,
    output logic                    p_ready_o,
    // Memory port
    output logic                    m_strobe_o,
    output dcache_pkg::mem_op_e     m_rw_o,
    output dcache_pkg::addr_t       m_addr_o,
    output dcache_pkg::line_t       m_data_o,
    input  logic                    m_ready_i,
    input  dcache_pkg::line_t       m_data_i
);

    dcache_pkg::addr_t  req_addr_q;
    dcache_pkg::word_t  req_data_q;
    dcache_pkg::be_t    req_be_q;
    logic               req_rw_q;
    dcache_pkg::line_t  refill_q;     // Line returned by memory

    dcache_pkg::set_t   idx_set;
    dcache_pkg::set_t   req_set;
    dcache_pkg::tag_t   req_tag;
    dcache_pkg::offs_t  req_offs;

    logic               hit;
    logic               victim_dirty;
    logic               fill;
    logic               data_we;
    logic               fill_we;
    logic               dirty_we;
    logic               dirty_val;
    logic               advance;
    dcache_pkg::way_t   hit_way;
    dcache_pkg::way_t   victim_way;
    dcache_pkg::way_t   way_sel;
    dcache_pkg::tag_t   victim_tag;
    dcache_pkg::line_t  way_line;

    // ========================================
    // Request capture
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            req_rw_q <= 1'b0;
        else if (p_strobe_i)
            req_rw_q <= p_rw_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (p_strobe_i)
        begin
            req_addr_q <= p_addr_i;
            req_data_q <= p_data_i;
            req_be_q   <= p_be_i;
        end
        if (m_ready_i && (m_rw_o == dcache_pkg::MEM_READ))
            refill_q <= m_data_i;  // Held for ST_FILL_DONE
    end

    assign req_set  = req_addr_q[dcache_pkg::SET_LSB +: dcache_pkg::SET_BITS];
    assign req_tag  = req_addr_q[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_BITS];
    assign req_offs = req_addr_q[dcache_pkg::OFFS_LSB +: dcache_pkg::WORD_BITS];

    // Live set on strobe so tags are ready in ST_LOOKUP
    assign idx_set = p_strobe_i ? p_addr_i[dcache_pkg::SET_LSB +: dcache_pkg::SET_BITS]
                                : req_set;

    // ========================================
    // Arrays, replacement and controller
    // ========================================
    dcache_tag_array u_tag (
        .clk_i (clk_i), .rst_i (rst_i),
        .set_i (idx_set), .tag_i (req_tag),
        .fill_we_i (fill_we), .fill_way_i (way_sel),
        .dirty_we_i (dirty_we), .dirty_way_i (way_sel), .dirty_val_i (dirty_val),
        .victim_way_i (victim_way),
        .hit_o (hit), .hit_way_o (hit_way),
        .victim_dirty_o (victim_dirty), .victim_tag_o (victim_tag)
    );

    dcache_data_array u_data (
        .clk_i (clk_i),
        .set_i (idx_set), .offs_i (req_offs),
        .we_i (data_we), .way_i (way_sel),
        .fill_i (fill), .fill_line_i (refill_q),
        .wr_i (req_rw_q), .be_i (req_be_q), .wdata_i (req_data_q),
        .line_o (way_line), .word_o (p_data_o)
    );

    dcache_fifo_repl u_repl (
        .clk_i (clk_i), .rst_i (rst_i),
        .set_i (idx_set), .advance_i (advance),
        .victim_o (victim_way)
    );

    dcache_ctrl u_ctrl (
        .clk_i (clk_i), .rst_i (rst_i),
        .p_strobe_i (p_strobe_i), .rw_i (req_rw_q),
        .hit_i (hit), .hit_way_i (hit_way),
        .victim_i (victim_way), .victim_dirty_i (victim_dirty), .victim_tag_i (victim_tag),
        .set_i (req_set), .victim_line_i (way_line), .fill_addr_i (req_addr_q),
        .m_ready_i (m_ready_i),
        .p_ready_o (p_ready_o), .fill_o (fill), .way_sel_o (way_sel),
        .data_we_o (data_we), .fill_we_o (fill_we),
        .dirty_we_o (dirty_we), .dirty_val_o (dirty_val), .advance_o (advance),
        .m_strobe_o (m_strobe_o), .m_rw_o (m_rw_o),
        .m_addr_o (m_addr_o), .m_data_o (m_data_o)
    );

endmodule

/* dv/dcache_mem_model.sv */
module dcache_mem_model
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    m_strobe_i,   // One-cycle request pulse from the cache
    input  dcache_pkg::mem_op_e     m_rw_i,
    input  dcache_pkg::addr_t       m_addr_i,     // Line aligned
    input  dcache_pkg::line_t       m_data_i,     // Victim line on a write-back
    output logic                    m_ready_o,
    output dcache_pkg::line_t       m_data_o      // Refill line, valid with ready
);
    timeunit 1ns;
    timeprecision 1ps;

    dcache_pkg::word_t mem_q [dcache_pkg::addr_t];  // Sparse, keyed by word address

    // Untouched words read back as an address pattern
    function automatic dcache_pkg::word_t read_word(dcache_pkg::addr_t a);
        if (mem_q.exists(a))
            return mem_q[a];
        return a ^ 32'h5a5a_0000;
    endfunction

    initial
    begin
        int                     lat;
        dcache_pkg::addr_t      base;
        dcache_pkg::mem_op_e    op;
        dcache_pkg::line_t      wline;
        void'($urandom(32'hdc299760));  // Latency sequence of the run
        m_ready_o = 1'b0;
        m_data_o  = '0;
        forever
        begin
            @(negedge clk_i);  // Request fields are stable here
            if (!rst_i && m_strobe_i)
            begin
                lat   = 1 + int'($urandom % 4);  // 1 to 4 cycles
                base  = m_addr_i;
                op    = m_rw_i;
                wline = m_data_i;
                repeat (lat) @(posedge clk_i);
                #1;
                for (int k = 0; k < 4; k++)
                begin
                    if (op == dcache_pkg::MEM_WRITE)
                        mem_q[base + dcache_pkg::addr_t'(k * 4)] = wline[k*32 +: 32];
                    else
                        m_data_o[k*32 +: 32] = read_word(base + dcache_pkg::addr_t'(k * 4));
                end
                m_ready_o = 1'b1;
                @(posedge clk_i);
                #1;
                m_ready_o = 1'b0;  // Single pulse
            end
        end
    end

endmodule

/* dv/dcache_tb.sv */
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic                   p_strobe;
    logic                   p_rw;
    dcache_pkg::be_t        p_be;
    dcache_pkg::addr_t      p_addr;
    dcache_pkg::word_t      p_wdata;
    dcache_pkg::word_t      p_rdata;
    logic                   p_ready;
    logic                   m_strobe;
    dcache_pkg::mem_op_e    m_rw;
    dcache_pkg::addr_t      m_addr;
    dcache_pkg::line_t      m_wline;
    logic                   m_ready;
    dcache_pkg::line_t      m_rline;

    // Stimulus queues, one entry per request line
    int                     op_q [$];
    dcache_pkg::addr_t      addr_q [$];
    dcache_pkg::be_t        be_q [$];
    dcache_pkg::word_t      data_q [$];
    int                     flag_q [$];

    logic [7:0]             shadow_q [dcache_pkg::addr_t];   // Bytes written so far
    dcache_pkg::addr_t      line_tab [dcache_pkg::N_SETS][dcache_pkg::N_WAYS];
    bit                     valid_tab [dcache_pkg::N_SETS][dcache_pkg::N_WAYS];
    bit                     dirty_tab [dcache_pkg::N_SETS][dcache_pkg::N_WAYS];
    int                     next_tab [dcache_pkg::N_SETS];   // FIFO pointer per set

    int                     wb_total = 0;
    dcache_pkg::addr_t      wb_addr;
    dcache_pkg::line_t      wb_line;
    int                     cycle_cnt = 0;
    int                     cycle_limit = 0;

    always #4 clk = ~clk;  // 8 ns period

    dcache_top u_dut (
        .clk_i (clk), .rst_i (rst),
        .p_strobe_i (p_strobe), .p_rw_i (p_rw), .p_be_i (p_be),
        .p_addr_i (p_addr), .p_data_i (p_wdata),
        .p_data_o (p_rdata), .p_ready_o (p_ready),
        .m_strobe_o (m_strobe), .m_rw_o (m_rw), .m_addr_o (m_addr), .m_data_o (m_wline),
        .m_ready_i (m_ready), .m_data_i (m_rline)
    );

    dcache_mem_model u_mem (
        .clk_i (clk), .rst_i (rst),
        .m_strobe_i (m_strobe), .m_rw_i (m_rw), .m_addr_i (m_addr), .m_data_i (m_wline),
        .m_ready_o (m_ready), .m_data_o (m_rline)
    );

    // ========================================
    // Error reporting and compare tasks
    // ========================================
    task automatic report_mismatch(string msg);
        $display("ERR @ %0d ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_word(dcache_pkg::word_t got, dcache_pkg::word_t exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_line(dcache_pkg::line_t got, dcache_pkg::line_t exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_addr(dcache_pkg::addr_t got, dcache_pkg::addr_t exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    // ========================================
    // Shadow memory and replacement model
    // ========================================
    function automatic dcache_pkg::word_t shadow_word(dcache_pkg::addr_t a);
        dcache_pkg::addr_t wa;
        dcache_pkg::word_t w;
        wa = {a[31:2], 2'b00};
        w  = wa ^ 32'h5a5a_0000;  // Pattern of memory never written
        for (int b = 0; b < 4; b++)
        begin
            if (shadow_q.exists(wa + dcache_pkg::addr_t'(b)))
                w[b*8 +: 8] = shadow_q[wa + dcache_pkg::addr_t'(b)];
        end
        return w;
    endfunction

    function automatic dcache_pkg::line_t shadow_line(dcache_pkg::addr_t la);
        dcache_pkg::line_t l;
        for (int k = 0; k < 4; k++)
            l[k*32 +: 32] = shadow_word(la + dcache_pkg::addr_t'(k * 4));
        return l;
    endfunction

    // Hit, write-back and victim line of a request, FIFO order per set
    task automatic predict(input dcache_pkg::addr_t a, input bit wr, output bit hit,
                           output bit wb, output dcache_pkg::addr_t victim);
        int                 s;
        int                 v;
        dcache_pkg::addr_t  la;
        la     = {a[31:4], 4'h0};
        s      = int'(a[dcache_pkg::SET_LSB +: dcache_pkg::SET_BITS]);
        hit    = 1'b0;
        wb     = 1'b0;
        victim = '0;
        for (int w = 0; w < dcache_pkg::N_WAYS; w++)
        begin
            if (valid_tab[s][w] && line_tab[s][w] == la)
            begin
                hit = 1'b1;
                if (wr)
                    dirty_tab[s][w] = 1'b1;
            end
        end
        if (!hit)
        begin
            v               = next_tab[s];
            wb              = valid_tab[s][v] && dirty_tab[s][v];  // Only dirty lines go out
            victim          = line_tab[s][v];
            line_tab[s][v]  = la;
            valid_tab[s][v] = 1'b1;
            dirty_tab[s][v] = wr;  // Write-allocate
            next_tab[s]     = (v + 1) % dcache_pkg::N_WAYS;
        end
    endtask

    // ========================================
    // One core request
    // ========================================
    task automatic run_request(int op, dcache_pkg::addr_t a, dcache_pkg::be_t be,
                               dcache_pkg::word_t d, int flag);
        bit                 hit;
        bit                 wb;
        dcache_pkg::addr_t  victim;
        dcache_pkg::word_t  exp_w;
        int                 waited;
        int                 wb_before;
        exp_w     = shadow_word(a);
        predict(a, op == 1, hit, wb, victim);
        wb_before = wb_total;
        @(posedge clk);
        #1;
        p_strobe = 1'b1;
        p_rw     = (op == 1);
        p_be     = be;
        p_addr   = a;
        p_wdata  = d;
        @(posedge clk);
        #1;
        p_strobe = 1'b0;  // Fields stay held until the next request
        waited   = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!p_ready);
        if (flag[1] && waited != 1)
            report_mismatch($sformatf("Address %h took %0d cycles, hit expected", a, waited));
        if (hit != (waited == 1))
            report_mismatch($sformatf("Address %h: %0d cycles, model hit is %0b", a, waited, hit));
        if (op == 0 && flag[0])
            check_word(p_rdata, exp_w, $sformatf("Read data at %h", a));
        if (wb_total - wb_before != (wb ? 1 : 0))
            report_mismatch($sformatf("Address %h: %0d write-backs, expected %0d",
                                      a, wb_total - wb_before, wb ? 1 : 0));
        if (wb)
        begin
            check_addr(wb_addr, victim, "Write-back address");
            check_line(wb_line, shadow_line(victim), "Write-back line");
        end
        if (op == 1)
        begin
            for (int b = 0; b < 4; b++)
                if (be[b])
                    shadow_q[{a[31:2], 2'b00} + dcache_pkg::addr_t'(b)] = d[b*8 +: 8];
        end
    endtask

    // Write-back strobes seen on the memory port
    always @(negedge clk)
    begin
        if (!rst && m_strobe && m_rw == dcache_pkg::MEM_WRITE)
        begin
            wb_total++;
            wb_addr = m_addr;
            wb_line = m_wline;
        end
    end

    // Run limit from the number of requests
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
            abort_run($sformatf("Timeout: requests still pending after %0d cycles", cycle_cnt));
    end

    initial
    begin
        int                 fd;
        int                 n;
        int                 op;
        int                 flag;
        string              line_s;
        dcache_pkg::addr_t  a;
        dcache_pkg::be_t    be;
        dcache_pkg::word_t  d;
        p_strobe = 1'b0;
        p_rw     = 1'b0;
        p_be     = '0;
        p_addr   = '0;
        p_wdata  = '0;
        fd = $fopen("dv/dcache_stim.txt", "r");
        if (fd == 0)
            abort_run("Could not open the stimulus file dv/dcache_stim.txt");
        while ($fgets(line_s, fd) != 0)
        begin
            n = $sscanf(line_s, "%d %h %h %h %d", op, a, be, d, flag);
            if (n == 5)  // Comment and blank lines do not parse
            begin
                op_q.push_back(op);
                addr_q.push_back(a);
                be_q.push_back(be);
                data_q.push_back(d);
                flag_q.push_back(flag);
            end
        end
        $fclose(fd);
        cycle_limit = 40 * op_q.size() + 100;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < op_q.size(); i++)
            run_request(op_q[i], addr_q[i], be_q[i], data_q[i], flag_q[i]);
        $display("** PASS **");
        $finish;
    end

endmodule

/* dv/dcache_stim.txt */
# op (0 read, 1 write)  address  byte-enables  write-data  check (bit0 data, bit1 hit)
# all values hex except op and check
0 00001000 f 00000000 1
0 00001004 f 00000000 3
1 00001008 1 000000ab 0
0 00001008 f 00000000 3
1 0000100c c beef0000 0
0 0000100c f 00000000 3
1 00002014 3 00001234 0
0 00002014 f 00000000 3
1 00002018 4 00cd0000 2
0 00002018 f 00000000 3
1 00010030 f 11111111 0
1 00020034 f 22222222 0
1 00030038 f 33333333 0
1 0004003c f 44444444 0
1 00050030 f 55555555 0
0 00100050 f 00000000 1
0 00200054 f 00000000 1
0 00300058 f 00000000 1
0 0040005c f 00000000 1
0 00500050 f 00000000 1
0 00100050 f 00000000 1
0 00001008 f 00000000 3
0 0000100c f 00000000 3
0 00002014 f 00000000 3
0 00002018 f 00000000 3
0 00010030 f 00000000 1
0 00020034 f 00000000 1
0 00030038 f 00000000 1
0 0004003c f 00000000 1
0 00050030 f 00000000 1

/* project.f */
hw/dcache_pkg.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_fifo_repl.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the data cache testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -j 0 -f project.f \
    --top-module dcache_tb -o dcache_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/dcache_sim 2>&1 | tee sim.log
[ -s sim.log ] && ! grep -qF '** FAIL **' sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
